// File: bench/ntm_lstm_cell_tb.sv
// Testbench for the LSTM cell top level: LCG stimulus, fixed-point model, checks by assertions
module ntm_lstm_cell_tb;

  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;
  localparam int SIZE_WIDTH = 8;

  localparam longint ONE   = longint'(1) << FRAC_BITS;
  localparam longint HALF  = ONE >>> 1;
  localparam longint MAX_W = (longint'(1) << (DATA_WIDTH - 1)) - 1;
  localparam longint MIN_W = -(longint'(1) << (DATA_WIDTH - 1));

  // Cycle limit from the runs below: loads plus ten cycles per element
  localparam int NUM_RUNS = 3;
  localparam int L_MAX    = 6;
  localparam int LOAD_CYC = 12;
  localparam int ELEM_CYC = 10;
  localparam int MARGIN   = 200;
  localparam int TIMEOUT  = NUM_RUNS * (LOAD_CYC + L_MAX * ELEM_CYC) + MARGIN;

  logic                         CLK = 1'b0;
  logic                         RST;
  logic                         i_start;
  logic [SIZE_WIDTH-1:0]        i_size_l;
  logic                         i_w_in_enable;
  logic signed [DATA_WIDTH-1:0] i_w_in;
  logic                         i_u_in_enable;
  logic signed [DATA_WIDTH-1:0] i_u_in;
  logic                         i_b_in_enable;
  logic signed [DATA_WIDTH-1:0] i_b_in;
  logic                         i_x_in_enable;
  logic signed [DATA_WIDTH-1:0] i_x_in;
  logic signed [DATA_WIDTH-1:0] i_h_in;
  logic signed [DATA_WIDTH-1:0] i_s_in;
  logic                         o_ready;
  logic                         o_h_out_enable;
  logic signed [DATA_WIDTH-1:0] o_h_out;
  logic signed [DATA_WIDTH-1:0] o_s_out;

  // Coefficients as loaded, index 0..3 is gate a, i, f, o
  longint                       cw [4];
  longint                       cu [4];
  longint                       cb [4];
  logic signed [DATA_WIDTH-1:0] exp_h_q [$];
  logic signed [DATA_WIDTH-1:0] exp_s_q [$];
  int                           n_seen     = 0;
  int                           run_pulses = 0;
  int                           ready_cnt  = 0;
  int                           run_len    = 0;
  int                           cycle_cnt  = 0;
  logic                         post_reset = 1'b0;
  logic                         run_end    = 1'b0;
  logic [31:0]                  lcg_state  = 32'h5dec;
  string                        test_name  = "reset";

  ntm_lstm_cell #(
    .DATA_WIDTH(DATA_WIDTH),
    .FRAC_BITS(FRAC_BITS),
    .SIZE_WIDTH(SIZE_WIDTH)
  ) u_dut (
    .CLK(CLK),
    .RST(RST),
    .i_start(i_start),
    .i_size_l(i_size_l),
    .i_w_in_enable(i_w_in_enable),
    .i_w_in(i_w_in),
    .i_u_in_enable(i_u_in_enable),
    .i_u_in(i_u_in),
    .i_b_in_enable(i_b_in_enable),
    .i_b_in(i_b_in),
    .i_x_in_enable(i_x_in_enable),
    .i_x_in(i_x_in),
    .i_h_in(i_h_in),
    .i_s_in(i_s_in),
    .o_ready(o_ready),
    .o_h_out_enable(o_h_out_enable),
    .o_h_out(o_h_out),
    .o_s_out(o_s_out)
  );

  always #2 CLK = ~CLK;

  //////////////////////////////
  // Random numbers and model
  //////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Uniform in -lim..lim, from the upper LCG bits
  function automatic int rand_signed(input int lim);
    lcg_state = lcg_step(lcg_state);
    return int'(lcg_state[31:16] % (2 * lim + 1)) - lim;
  endfunction

  function automatic longint clamp(input longint v, input longint lo, input longint hi);
    if (v > hi) begin
      return hi;
    end else if (v < lo) begin
      return lo;
    end
    return v;
  endfunction

  function automatic longint q_mul(input longint a, input longint b);
    return (a * b) >>> FRAC_BITS;
  endfunction

  function automatic longint saturate(input longint v);
    return clamp(v, MIN_W, MAX_W);
  endfunction

  function automatic longint hard_sigmoid(input longint p);
    return clamp((p >>> 2) + HALF, 0, ONE);
  endfunction

  function automatic longint hard_tanh(input longint p);
    return clamp(p, -ONE, ONE);
  endfunction

  function automatic longint gate_model(input int g, input longint x, input longint h);
    longint p;
    p = saturate(q_mul(cw[g], x) + q_mul(cu[g], h) + cb[g]);
    if (g == 0) begin
      return hard_tanh(p);
    end
    return hard_sigmoid(p);
  endfunction

  //////////////////////////////
  // Failure reporting
  //////////////////////////////

  task automatic report_mismatch(input string what, input longint exp_v, input longint act_v);
    $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, exp_v, act_v);
    $display("Simulation failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic stop_with_error(input string msg);
    $display("error in %s: %s", test_name, msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      stop_with_error($sformatf("run did not finish within %0d cycles", TIMEOUT));
    end
  end

  // Output and run counters, cleared by each start
  always @(posedge CLK) begin
    if (o_h_out_enable) begin
      n_seen <= n_seen + 1;
    end
    if (i_start) begin
      run_pulses <= 0;
      ready_cnt  <= 0;
      run_len    <= int'(i_size_l);
    end else begin
      if (o_h_out_enable) begin
        run_pulses <= run_pulses + 1;
      end
      if (o_ready) begin
        ready_cnt <= ready_cnt + 1;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_reset_zero : assert property (@(posedge CLK) disable iff (RST)
    post_reset |-> (!o_ready && !o_h_out_enable && o_h_out == 0 && o_s_out == 0))
    else stop_with_error("outputs are not zero after reset");

  a_h_value : assert property (@(posedge CLK) disable iff (RST)
    o_h_out_enable |-> o_h_out == exp_h_q[n_seen])
    else report_mismatch("o_h_out", exp_h_q[$sampled(n_seen)], $sampled(o_h_out));

  a_s_value : assert property (@(posedge CLK) disable iff (RST)
    o_h_out_enable |-> o_s_out == exp_s_q[n_seen])
    else report_mismatch("o_s_out", exp_s_q[$sampled(n_seen)], $sampled(o_s_out));

  // Pulse in the cycle after the seventh edge, never one earlier
  a_latency : assert property (@(posedge CLK) disable iff (RST)
    i_x_in_enable |-> ##7 !o_h_out_enable ##1 o_h_out_enable)
    else stop_with_error("o_h_out_enable did not rise exactly 7 cycles after the element");

  a_ready_with_output : assert property (@(posedge CLK) disable iff (RST)
    o_ready |-> o_h_out_enable)
    else stop_with_error("o_ready pulsed without an output pulse");

  a_ready_on_last : assert property (@(posedge CLK) disable iff (RST)
    o_h_out_enable |-> (o_ready == (run_pulses == run_len - 1)))
    else stop_with_error("o_ready does not line up with the last element of the run");

  a_run_total : assert property (@(posedge CLK) disable iff (RST)
    run_end |-> (run_pulses == run_len && ready_cnt == 1))
    else stop_with_error("output or ready pulse count differs from i_size_l");

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic load_coefs(input int lim);
    for (int g = 0; g < 4; g++) begin
      @(posedge CLK);
      cw[g] = rand_signed(lim);
      cu[g] = rand_signed(lim);
      cb[g] = rand_signed(lim);
      i_w_in_enable <= 1'b1;
      i_u_in_enable <= 1'b1;
      i_b_in_enable <= 1'b1;
      i_w_in        <= DATA_WIDTH'(cw[g]);
      i_u_in        <= DATA_WIDTH'(cu[g]);
      i_b_in        <= DATA_WIDTH'(cb[g]);
    end
    @(posedge CLK);
    i_w_in_enable <= 1'b0;
    i_u_in_enable <= 1'b0;
    i_b_in_enable <= 1'b0;
  endtask

  task automatic start_run(input int len);
    @(posedge CLK);
    i_start  <= 1'b1;
    i_size_l <= SIZE_WIDTH'(len);
    @(posedge CLK);
    i_start  <= 1'b0;
  endtask

  // Returns on the edge that samples the strobe
  task automatic send_element(input int lim);
    longint x;
    longint h;
    longint s;
    longint s_new;
    longint h_new;
    x = rand_signed(lim);
    h = rand_signed(lim);
    s = rand_signed(lim);
    s_new = saturate(q_mul(gate_model(2, x, h), s) + q_mul(gate_model(1, x, h),
                                                            gate_model(0, x, h)));
    h_new = saturate(q_mul(gate_model(3, x, h), hard_tanh(s_new)));
    exp_s_q.push_back(DATA_WIDTH'(s_new));
    exp_h_q.push_back(DATA_WIDTH'(h_new));
    @(posedge CLK);
    i_x_in_enable <= 1'b1;
    i_x_in        <= DATA_WIDTH'(x);
    i_h_in        <= DATA_WIDTH'(h);
    i_s_in        <= DATA_WIDTH'(s);
    @(posedge CLK);
    i_x_in_enable <= 1'b0;
  endtask

  task automatic wait_output();
    @(posedge CLK);
    while (!o_h_out_enable) begin
      @(posedge CLK);
    end
  endtask

  task automatic wait_ready();
    @(posedge CLK);
    while (!o_ready) begin
      @(posedge CLK);
    end
  endtask

  // Mode 0 back to back, 1 gapped, 2 alternating
  task automatic run_sequence(input string name, input int coef_lim, input int in_lim,
                              input int len, input int mode);
    int gap;
    test_name = name;
    load_coefs(coef_lim);
    start_run(len);
    for (int k = 0; k < len; k++) begin
      send_element(in_lim);
      if (k < len - 1) begin
        if (mode == 0 || (mode == 2 && k % 2 == 0)) begin
          // Next strobe lands in the cycle of this element's output pulse
          repeat (6) @(posedge CLK);
        end else begin
          wait_output();
          gap = rand_signed(1) + 1;
          repeat (gap) @(posedge CLK);
        end
      end
    end
    wait_ready();
    run_end <= 1'b1;
    @(posedge CLK);
    run_end <= 1'b0;
  endtask

  initial begin
    RST           = 1'b1;
    i_start       = 1'b0;
    i_size_l      = '0;
    i_w_in_enable = 1'b0;
    i_w_in        = '0;
    i_u_in_enable = 1'b0;
    i_u_in        = '0;
    i_b_in_enable = 1'b0;
    i_b_in        = '0;
    i_x_in_enable = 1'b0;
    i_x_in        = '0;
    i_h_in        = '0;
    i_s_in        = '0;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    post_reset <= 1'b1;
    repeat (2) @(posedge CLK);
    post_reset <= 1'b0;
    run_sequence("random", 512, 512, 6, 0);
    run_sequence("saturation", 32000, 32000, 4, 1);
    // Second load of four per kind, pointers back at gate a
    run_sequence("reload", 512, 512, 5, 2);
    repeat (2) @(posedge CLK);
    if (n_seen != exp_h_q.size()) begin
      stop_with_error($sformatf("%0d outputs for %0d elements", n_seen, exp_h_q.size()));
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// File: flist.f
hdl/ntm_lstm_pkg.sv
hdl/ntm_coef_bank.sv
hdl/ntm_gate_vector.sv
hdl/ntm_cell_update.sv
hdl/ntm_lstm_controller.sv
hdl/ntm_lstm_cell.sv
bench/ntm_lstm_cell_tb.sv

// File: hdl/ntm_cell_update.sv
// Cell update: collects the four gate results, then new state and hidden value on step pulses
module ntm_cell_update
  import ntm_lstm_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int FRAC_BITS  = 8
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         i_valid,
  input  gate_e                        i_gate_sel,
  input  logic signed [DATA_WIDTH-1:0] i_gate,
  input  logic signed [DATA_WIDTH-1:0] i_s_prev,
  input  logic                         i_state_step,
  input  logic                         i_hidden_step,
  output logic                         o_h_out_enable,
  output logic signed [DATA_WIDTH-1:0] o_h_out,
  output logic signed [DATA_WIDTH-1:0] o_s_out
);

  localparam int PW = 2 * DATA_WIDTH;

  localparam logic signed [DATA_WIDTH-1:0] MAX_Q = {1'b0, {(DATA_WIDTH-1){1'b1}}};
  localparam logic signed [DATA_WIDTH-1:0] MIN_Q = {1'b1, {(DATA_WIDTH-1){1'b0}}};
  localparam logic signed [DATA_WIDTH-1:0] ONE_Q = DATA_WIDTH'(1 << FRAC_BITS);

  logic signed [DATA_WIDTH-1:0] gate_a_q;
  logic signed [DATA_WIDTH-1:0] gate_i_q;
  logic signed [DATA_WIDTH-1:0] gate_f_q;
  logic signed [DATA_WIDTH-1:0] gate_o_q;
  logic signed [DATA_WIDTH-1:0] s_q;
  logic signed [DATA_WIDTH-1:0] h_q;
  logic                         h_en_q;
  logic signed [PW+1:0]         s_sum;
  logic signed [PW+1:0]         h_sum;

  function automatic logic signed [PW-1:0] mul_q(input logic signed [DATA_WIDTH-1:0] a,
                                                 input logic signed [DATA_WIDTH-1:0] b);
    logic signed [PW-1:0] full;
    full = a * b;
    return full >>> FRAC_BITS;
  endfunction

  function automatic logic signed [DATA_WIDTH-1:0] sat_q(input logic signed [PW+1:0] v);
    if (v > MAX_Q) begin
      return MAX_Q;
    end else if (v < MIN_Q) begin
      return MIN_Q;
    end
    return v[DATA_WIDTH-1:0];
  endfunction

  function automatic logic signed [DATA_WIDTH-1:0] tanh_q(input logic signed [DATA_WIDTH-1:0] v);
    if (v > ONE_Q) begin
      return ONE_Q;
    end else if (v < -ONE_Q) begin
      return -ONE_Q;
    end
    return v;
  endfunction

  // Gate results land in the register named by their tag
  always_ff @(posedge CLK) begin
    if (i_valid) begin
      case (i_gate_sel)
        GATE_A: gate_a_q <= i_gate;
        GATE_I: gate_i_q <= i_gate;
        GATE_F: gate_f_q <= i_gate;
        default: gate_o_q <= i_gate;
      endcase
    end
  end

  // s = f*s_prev + i*a, h = o*tanh(s)
  always_comb begin
    s_sum = mul_q(gate_f_q, i_s_prev) + mul_q(gate_i_q, gate_a_q);
    h_sum = mul_q(gate_o_q, tanh_q(s_q));
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s_q    <= '0;
      h_q    <= '0;
      h_en_q <= 1'b0;
    end else begin
      h_en_q <= i_hidden_step;
      if (i_state_step) begin
        s_q <= sat_q(s_sum);
      end
      if (i_hidden_step) begin
        h_q <= sat_q(h_sum);
      end
    end
  end

  assign o_s_out        = s_q;
  assign o_h_out        = h_q;
  assign o_h_out_enable = h_en_q;

  // Hidden step must read the state written one cycle earlier
  a_step_order : assert property (@(posedge CLK) disable iff (RST)
    i_state_step |-> !i_hidden_step ##1 i_hidden_step);

endmodule

// File: hdl/ntm_coef_bank.sv
// Gate coefficient store: W, U and B strobes fill gates a, i, f, o in turn, read by gate select
module ntm_coef_bank
  import ntm_lstm_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         i_load_allow,
  input  logic                         i_w_in_enable,
  input  logic signed [DATA_WIDTH-1:0] i_w_in,
  input  logic                         i_u_in_enable,
  input  logic signed [DATA_WIDTH-1:0] i_u_in,
  input  logic                         i_b_in_enable,
  input  logic signed [DATA_WIDTH-1:0] i_b_in,
  input  gate_e                        i_gate_sel,
  output logic signed [DATA_WIDTH-1:0] o_w,
  output logic signed [DATA_WIDTH-1:0] o_u,
  output logic signed [DATA_WIDTH-1:0] o_b
);

  // Coefficient kinds, one row each
  localparam int NUM_KINDS = 3;
  localparam int KIND_W    = 0;
  localparam int KIND_U    = 1;
  localparam int KIND_B    = 2;
  localparam int PTR_WIDTH = $clog2(NUM_GATES);

  logic [NUM_KINDS-1:0]         wr_en;
  logic signed [DATA_WIDTH-1:0] wr_data [NUM_KINDS];
  logic [PTR_WIDTH-1:0]         ptr_q [NUM_KINDS];
  logic signed [DATA_WIDTH-1:0] coef_q [NUM_KINDS][NUM_GATES];

  // Strobes only count while the controller is idle
  assign wr_en = {i_b_in_enable, i_u_in_enable, i_w_in_enable} & {NUM_KINDS{i_load_allow}};

  assign wr_data[KIND_W] = i_w_in;
  assign wr_data[KIND_U] = i_u_in;
  assign wr_data[KIND_B] = i_b_in;

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int k = 0; k < NUM_KINDS; k++) begin
        ptr_q[k] <= '0;
        for (int g = 0; g < NUM_GATES; g++) begin
          coef_q[k][g] <= '0;
        end
      end
    end else begin
      for (int k = 0; k < NUM_KINDS; k++) begin
        if (wr_en[k]) begin
          coef_q[k][ptr_q[k]] <= wr_data[k];
          // Wraps back to gate a after gate o
          ptr_q[k]            <= ptr_q[k] + 1'b1;
        end
      end
    end
  end

  // Read side is combinational
  assign o_w = coef_q[KIND_W][i_gate_sel];
  assign o_u = coef_q[KIND_U][i_gate_sel];
  assign o_b = coef_q[KIND_B][i_gate_sel];

  // Loading while a run is active would corrupt the gate in flight
  a_load_only_idle : assert property (@(posedge CLK) disable iff (RST)
    (i_w_in_enable || i_u_in_enable || i_b_in_enable) |-> i_load_allow);

endmodule

// File: hdl/ntm_gate_vector.sv
// Shared gate unit: w*x + u*h + b, then hard tanh (gate a) or hard sigmoid, one register stage
module ntm_gate_vector
  import ntm_lstm_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int FRAC_BITS  = 8
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         i_valid,
  input  gate_e                        i_gate_sel,
  input  logic signed [DATA_WIDTH-1:0] i_x,
  input  logic signed [DATA_WIDTH-1:0] i_h,
  input  logic signed [DATA_WIDTH-1:0] i_w,
  input  logic signed [DATA_WIDTH-1:0] i_u,
  input  logic signed [DATA_WIDTH-1:0] i_b,
  output logic                         o_valid,
  output gate_e                        o_gate_sel,
  output logic signed [DATA_WIDTH-1:0] o_gate
);

  localparam int PW = 2 * DATA_WIDTH;

  localparam logic signed [DATA_WIDTH-1:0] MAX_Q  = {1'b0, {(DATA_WIDTH-1){1'b1}}};
  localparam logic signed [DATA_WIDTH-1:0] MIN_Q  = {1'b1, {(DATA_WIDTH-1){1'b0}}};
  localparam logic signed [DATA_WIDTH-1:0] ONE_Q  = DATA_WIDTH'(1 << FRAC_BITS);
  localparam logic signed [DATA_WIDTH-1:0] HALF_Q = ONE_Q >>> 1;

  logic signed [PW+1:0]         pre_sum;
  logic signed [DATA_WIDTH-1:0] pre_act;
  logic signed [DATA_WIDTH:0]   sig_raw;
  logic signed [DATA_WIDTH-1:0] act;

  //////////////////////////////
  // Fixed-point helpers
  //////////////////////////////

  // Full product, scaled back to the Q format
  function automatic logic signed [PW-1:0] mul_q(input logic signed [DATA_WIDTH-1:0] a,
                                                 input logic signed [DATA_WIDTH-1:0] b);
    logic signed [PW-1:0] full;
    full = a * b;
    return full >>> FRAC_BITS;
  endfunction

  function automatic logic signed [DATA_WIDTH-1:0] sat_q(input logic signed [PW+1:0] v);
    if (v > MAX_Q) begin
      return MAX_Q;
    end else if (v < MIN_Q) begin
      return MIN_Q;
    end
    return v[DATA_WIDTH-1:0];
  endfunction

  //////////////////////////////
  // Pre-activation and activation
  //////////////////////////////

  always_comb begin
    pre_sum = mul_q(i_w, i_x) + mul_q(i_u, i_h) + i_b;
    pre_act = sat_q(pre_sum);
    sig_raw = (pre_act >>> 2) + HALF_Q;
    if (i_gate_sel == GATE_A) begin
      // Hard tanh
      if (pre_act > ONE_Q) begin
        act = ONE_Q;
      end else if (pre_act < -ONE_Q) begin
        act = -ONE_Q;
      end else begin
        act = pre_act;
      end
    end else begin
      // Hard sigmoid, p/4 + 0.5
      if (sig_raw > ONE_Q) begin
        act = ONE_Q;
      end else if (sig_raw < 0) begin
        act = '0;
      end else begin
        act = sig_raw[DATA_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // Result and tag travel together
  always_ff @(posedge CLK) begin
    o_gate     <= act;
    o_gate_sel <= i_gate_sel;
  end

  a_sigmoid_range : assert property (@(posedge CLK) disable iff (RST)
    (o_valid && o_gate_sel != GATE_A) |-> (o_gate >= 0 && o_gate <= ONE_Q));

endmodule

// File: hdl/ntm_lstm_cell.sv
// Fixed-point LSTM cell top level wiring the controller, coefficient bank, gate unit and cell update
module ntm_lstm_cell
  import ntm_lstm_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int FRAC_BITS  = 8,
  parameter int SIZE_WIDTH = 8
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         i_start,
  input  logic [SIZE_WIDTH-1:0]        i_size_l,
  input  logic                         i_w_in_enable,
  input  logic signed [DATA_WIDTH-1:0] i_w_in,
  input  logic                         i_u_in_enable,
  input  logic signed [DATA_WIDTH-1:0] i_u_in,
  input  logic                         i_b_in_enable,
  input  logic signed [DATA_WIDTH-1:0] i_b_in,
  input  logic                         i_x_in_enable,
  input  logic signed [DATA_WIDTH-1:0] i_x_in,
  input  logic signed [DATA_WIDTH-1:0] i_h_in,
  input  logic signed [DATA_WIDTH-1:0] i_s_in,
  output logic                         o_ready,
  output logic                         o_h_out_enable,
  output logic signed [DATA_WIDTH-1:0] o_h_out,
  output logic signed [DATA_WIDTH-1:0] o_s_out
);

  logic                         load_allow;
  logic                         gate_valid;
  gate_e                        gate_sel;
  logic signed [DATA_WIDTH-1:0] elem_x;
  logic signed [DATA_WIDTH-1:0] elem_h;
  logic signed [DATA_WIDTH-1:0] s_prev;
  logic                         state_step;
  logic                         hidden_step;
  logic signed [DATA_WIDTH-1:0] coef_w;
  logic signed [DATA_WIDTH-1:0] coef_u;
  logic signed [DATA_WIDTH-1:0] coef_b;
  logic                         res_valid;
  gate_e                        res_sel;
  logic signed [DATA_WIDTH-1:0] res_gate;

  //////////////////////////////
  // Control
  //////////////////////////////

  ntm_lstm_controller #(
    .DATA_WIDTH(DATA_WIDTH),
    .SIZE_WIDTH(SIZE_WIDTH)
  ) u_ctrl (
    .CLK(CLK),
    .RST(RST),
    .i_start(i_start),
    .i_size_l(i_size_l),
    .i_x_in_enable(i_x_in_enable),
    .i_x_in(i_x_in),
    .i_h_in(i_h_in),
    .i_s_in(i_s_in),
    .i_h_done(o_h_out_enable),
    .o_load_allow(load_allow),
    .o_gate_valid(gate_valid),
    .o_gate_sel(gate_sel),
    .o_x(elem_x),
    .o_h(elem_h),
    .o_s_prev(s_prev),
    .o_state_step(state_step),
    .o_hidden_step(hidden_step),
    .o_ready(o_ready)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  ntm_coef_bank #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_coef (
    .CLK(CLK),
    .RST(RST),
    .i_load_allow(load_allow),
    .i_w_in_enable(i_w_in_enable),
    .i_w_in(i_w_in),
    .i_u_in_enable(i_u_in_enable),
    .i_u_in(i_u_in),
    .i_b_in_enable(i_b_in_enable),
    .i_b_in(i_b_in),
    .i_gate_sel(gate_sel),
    .o_w(coef_w),
    .o_u(coef_u),
    .o_b(coef_b)
  );

  ntm_gate_vector #(
    .DATA_WIDTH(DATA_WIDTH),
    .FRAC_BITS(FRAC_BITS)
  ) u_gate (
    .CLK(CLK),
    .RST(RST),
    .i_valid(gate_valid),
    .i_gate_sel(gate_sel),
    .i_x(elem_x),
    .i_h(elem_h),
    .i_w(coef_w),
    .i_u(coef_u),
    .i_b(coef_b),
    .o_valid(res_valid),
    .o_gate_sel(res_sel),
    .o_gate(res_gate)
  );

  ntm_cell_update #(
    .DATA_WIDTH(DATA_WIDTH),
    .FRAC_BITS(FRAC_BITS)
  ) u_update (
    .CLK(CLK),
    .RST(RST),
    .i_valid(res_valid),
    .i_gate_sel(res_sel),
    .i_gate(res_gate),
    .i_s_prev(s_prev),
    .i_state_step(state_step),
    .i_hidden_step(hidden_step),
    .o_h_out_enable(o_h_out_enable),
    .o_h_out(o_h_out),
    .o_s_out(o_s_out)
  );

  // Accepted element gives its output pulse in the cycle after the seventh edge
  a_elem_latency : assert property (@(posedge CLK) disable iff (RST)
    (i_x_in_enable && u_ctrl.state_q == WAIT_ELEMENT) |-> ##8 o_h_out_enable);

endmodule

// File: hdl/ntm_lstm_controller.sv
// LSTM sequencer FSM: latches elements, issues the four gates, state and hidden steps, ready
module ntm_lstm_controller
  import ntm_lstm_pkg::*;
#(
  parameter int DATA_WIDTH = 16,
  parameter int SIZE_WIDTH = 8
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         i_start,
  input  logic [SIZE_WIDTH-1:0]        i_size_l,
  input  logic                         i_x_in_enable,
  input  logic signed [DATA_WIDTH-1:0] i_x_in,
  input  logic signed [DATA_WIDTH-1:0] i_h_in,
  input  logic signed [DATA_WIDTH-1:0] i_s_in,
  input  logic                         i_h_done,
  output logic                         o_load_allow,
  output logic                         o_gate_valid,
  output gate_e                        o_gate_sel,
  output logic signed [DATA_WIDTH-1:0] o_x,
  output logic signed [DATA_WIDTH-1:0] o_h,
  output logic signed [DATA_WIDTH-1:0] o_s_prev,
  output logic                         o_state_step,
  output logic                         o_hidden_step,
  output logic                         o_ready
);

  // One extra count drains the last gate out of the pipeline
  localparam int GATE_CNT_WIDTH = $clog2(NUM_GATES + 1);

  ctrl_state_e                  state_q;
  logic [GATE_CNT_WIDTH-1:0]    gate_cnt_q;
  logic [SIZE_WIDTH-1:0]        size_q;
  logic [SIZE_WIDTH-1:0]        elem_cnt_q;
  logic                         last_elem;
  logic                         elem_take;
  logic signed [DATA_WIDTH-1:0] x_q;
  logic signed [DATA_WIDTH-1:0] h_q;
  logic signed [DATA_WIDTH-1:0] s_q;

  // elem_cnt_q counts finished elements
  assign last_elem = (elem_cnt_q == size_q - 1'b1);
  assign elem_take = (state_q == WAIT_ELEMENT) && i_x_in_enable;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q    <= STARTER;
      gate_cnt_q <= '0;
      size_q     <= '0;
      elem_cnt_q <= '0;
    end else begin
      if (i_h_done) begin
        elem_cnt_q <= elem_cnt_q + 1'b1;
      end
      case (state_q)
        STARTER: begin
          if (i_start) begin
            size_q     <= i_size_l;
            elem_cnt_q <= '0;
            state_q    <= WAIT_ELEMENT;
          end
        end
        WAIT_ELEMENT: begin
          if (i_x_in_enable) begin
            gate_cnt_q <= '0;
            state_q    <= GATE_ISSUE;
          end
        end
        GATE_ISSUE: begin
          gate_cnt_q <= gate_cnt_q + 1'b1;
          if (gate_cnt_q == GATE_CNT_WIDTH'(NUM_GATES)) begin
            state_q <= STATE_STEP;
          end
        end
        STATE_STEP: begin
          state_q <= HIDDEN_STEP;
        end
        HIDDEN_STEP: begin
          state_q <= last_elem ? STARTER : WAIT_ELEMENT;
        end
        default: begin
          state_q <= STARTER;
        end
      endcase
    end
  end

  // Element triple, held until the next element is taken
  always_ff @(posedge CLK) begin
    if (elem_take) begin
      x_q <= i_x_in;
      h_q <= i_h_in;
      s_q <= i_s_in;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign o_load_allow  = (state_q == STARTER);
  assign o_gate_valid  = (state_q == GATE_ISSUE) && (gate_cnt_q < NUM_GATES);
  assign o_gate_sel    = gate_e'(gate_cnt_q[1:0]);
  assign o_x           = x_q;
  assign o_h           = h_q;
  assign o_s_prev      = s_q;
  assign o_state_step  = (state_q == STATE_STEP);
  assign o_hidden_step = (state_q == HIDDEN_STEP);
  // Ready goes out with the last hidden value
  assign o_ready       = i_h_done && last_elem;

  a_elem_in_wait : assert property (@(posedge CLK) disable iff (RST)
    i_x_in_enable |-> state_q == WAIT_ELEMENT);

  a_start_in_idle : assert property (@(posedge CLK) disable iff (RST)
    i_start |-> state_q == STARTER);

endmodule

// File: hdl/ntm_lstm_pkg.sv
// Shared LSTM cell types, imported by the controller and datapath modules
package ntm_lstm_pkg;

  //////////////////////////////
  // Gates
  //////////////////////////////

  // Gate tags, also the coefficient load order
  typedef enum logic [1:0] {
    GATE_A = 2'd0,  // activation, hard tanh
    GATE_I = 2'd1,  // input, hard sigmoid
    GATE_F = 2'd2,  // forget, hard sigmoid
    GATE_O = 2'd3   // output, hard sigmoid
  } gate_e;

  localparam int NUM_GATES = 4;

  //////////////////////////////
  // Controller
  //////////////////////////////

  // Per element: wait, four gate issues plus drain, state step, hidden step
  typedef enum logic [2:0] {
    STARTER      = 3'd0,
    WAIT_ELEMENT = 3'd1,
    GATE_ISSUE   = 3'd2,
    STATE_STEP   = 3'd3,
    HIDDEN_STEP  = 3'd4
  } ctrl_state_e;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the LSTM cell testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f flist.f \
  --top-module ntm_lstm_cell_tb -Mdir obj_dir -o ntm_lstm_cell_sim

# The log decides the result, a fatal stop still leaves its lines there
./obj_dir/ntm_lstm_cell_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log || ! grep -q "Simulation completed successfully" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
